/* alu.sv */
// Combinational ALU for arithmetic, logic, compare, shift and LUI, also used for load/store addresses
`timescale 1ns/1ps

module alu (
    decodeIf.consumer dec,
    input mipsPkg::word_t rsData,
    input mipsPkg::word_t rtData,
    output mipsPkg::word_t result
);
    mipsPkg::word_t immExt;
    mipsPkg::word_t operandB;

    // Immediate extension as the decoder requests
    assign immExt = dec.immZeroExtend ? {16'b0, dec.imm} : {{16{dec.imm[15]}}, dec.imm};
    assign operandB = dec.useImm ? immExt : rtData;

    always_comb begin
        case (dec.aluOp)
            mipsPkg::aluAdd: result = rsData + operandB;
            mipsPkg::aluSub: result = rsData - operandB;
            mipsPkg::aluAnd: result = rsData & operandB;
            mipsPkg::aluOr: result = rsData | operandB;
            mipsPkg::aluXor: result = rsData ^ operandB;
            // Signed compare
            mipsPkg::aluSlt: begin
                result = {31'b0, $signed(rsData) < $signed(operandB)};
            end
            mipsPkg::aluSltu: begin
                result = {31'b0, rsData < operandB};
            end
            // Shifts by shamt act on rt only
            mipsPkg::aluSll: result = rtData << dec.shamt;
            mipsPkg::aluSrl: result = rtData >> dec.shamt;
            mipsPkg::aluSra: begin
                result = mipsPkg::word_t'($signed(rtData) >>> dec.shamt);
            end
            mipsPkg::aluLui: result = {dec.imm, 16'b0};
            default: result = '0;
        endcase
    end
endmodule

/* compile.f */
mipsPkg.sv
decodeIf.sv
instrDecoder.sv
registerFile.sv
alu.sv
pcUnit.sv
cpuControl.sv
mipsCpuBus.sv
tbMipsCpu.sv

/* cpuControl.sv */
// Fetch/execute/memory/halt FSM driving the Avalon master strobes and the datapath update enables
`timescale 1ns/1ps

module cpuControl (
    input logic clk,
    input logic reset,
    decodeIf.consumer dec,
    input mipsPkg::word_t pc,
    input mipsPkg::word_t aluResult,
    input logic waitrequest,
    output mipsPkg::word_t address,
    output logic read,
    output logic write,
    output logic active,
    output logic [3:0] byteenable,
    output logic instrLoad,
    output logic regWrite,
    output logic pcAdvance,
    output mipsPkg::wbSel_t writeSelect
);
    mipsPkg::cpuState_t state;
    mipsPkg::cpuState_t nextState;
    // Low during reset, keeps the bus idle until the first cycle after it
    logic started;
    logic fetchLive;
    logic haltFetch;

    // Fetch outcome for the current PC
    assign fetchLive = (state == mipsPkg::stFetch) && started;
    assign haltFetch = fetchLive && (pc == mipsPkg::haltAddress);

    // Word accesses only
    assign byteenable = mipsPkg::fullByteEnable;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= mipsPkg::stFetch;
            started <= 1'b0;
            active <= 1'b1;
        end else begin
            state <= nextState;
            started <= 1'b1;
            // Drops on the edge that enters HALT
            if (haltFetch) begin
                active <= 1'b0;
            end
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            mipsPkg::stFetch: begin
                if (haltFetch) begin
                    nextState = mipsPkg::stHalt;
                end else if (fetchLive && !waitrequest) begin
                    nextState = mipsPkg::stExec;
                end
            end
            // Single cycle, memory ops continue in MEM
            mipsPkg::stExec: begin
                if (dec.isLoad || dec.isStore) begin
                    nextState = mipsPkg::stMem;
                end else begin
                    nextState = mipsPkg::stFetch;
                end
            end
            mipsPkg::stMem: begin
                if (!waitrequest) begin
                    nextState = mipsPkg::stFetch;
                end
            end
            // Only reset leaves HALT
            default: nextState = mipsPkg::stHalt;
        endcase
    end

    always_comb begin
        address = pc;
        read = 1'b0;
        write = 1'b0;
        instrLoad = 1'b0;
        regWrite = 1'b0;
        pcAdvance = 1'b0;
        writeSelect = mipsPkg::wbAlu;
        case (state)
            mipsPkg::stFetch: begin
                read = fetchLive && !haltFetch;
                // Capture in the completing cycle
                instrLoad = read && !waitrequest;
            end
            mipsPkg::stExec: begin
                pcAdvance = 1'b1;
                regWrite = dec.writesReg && !dec.isLoad;
                writeSelect = dec.linkWrite ? mipsPkg::wbLink : mipsPkg::wbAlu;
            end
            mipsPkg::stMem: begin
                // ALU holds base plus offset for the whole access
                address = aluResult;
                read = dec.isLoad;
                write = dec.isStore;
                regWrite = dec.isLoad && !waitrequest;
                writeSelect = mipsPkg::wbLoad;
            end
            default: begin
                address = pc;
            end
        endcase
    end
endmodule

/* decodeIf.sv */
// Decoded instruction fields passed from the decoder to the register file, ALU, PC and FSM
`timescale 1ns/1ps

interface decodeIf;
    // Raw register fields
    mipsPkg::regAddr_t rs;
    mipsPkg::regAddr_t rt;
    mipsPkg::regAddr_t rd;
    mipsPkg::shamt_t shamt;
    mipsPkg::imm_t imm;
    logic [25:0] target;
    // Execution controls
    mipsPkg::aluOp_t aluOp;
    logic useImm;
    logic immZeroExtend;
    // Writeback, destination already resolved to rd, rt or ra
    logic writesReg;
    mipsPkg::regAddr_t destReg;
    logic linkWrite;
    // Memory and flow classes
    logic isLoad;
    logic isStore;
    mipsPkg::branchKind_t branchKind;

    modport producer (
        output rs, rt, rd, shamt, imm, target, aluOp, useImm, immZeroExtend,
        output writesReg, destReg, linkWrite, isLoad, isStore, branchKind
    );

    modport consumer (
        input rs, rt, rd, shamt, imm, target, aluOp, useImm, immZeroExtend,
        input writesReg, destReg, linkWrite, isLoad, isStore, branchKind
    );
endinterface

/* instrDecoder.sv */
// Instruction register and decoder feeding the decodeIf bundle to the rest of the core
`timescale 1ns/1ps

module instrDecoder (
    input logic clk,
    input logic reset,
    input logic instrLoad,
    input mipsPkg::word_t readdata,
    decodeIf.producer dec
);
    mipsPkg::word_t instrReg;
    mipsPkg::opcode_t opcode;
    mipsPkg::funct_t funct;

    // Cleared to all zeros, which is SLL r0 and writes nothing
    always_ff @(posedge clk) begin
        if (reset) begin
            instrReg <= '0;
        end else if (instrLoad) begin
            instrReg <= readdata;
        end
    end

    // Field split
    assign opcode = mipsPkg::opcode_t'(instrReg[31:26]);
    assign funct = mipsPkg::funct_t'(instrReg[5:0]);
    assign dec.rs = instrReg[25:21];
    assign dec.rt = instrReg[20:16];
    assign dec.rd = instrReg[15:11];
    assign dec.shamt = instrReg[10:6];
    assign dec.imm = instrReg[15:0];
    assign dec.target = instrReg[25:0];

    always_comb begin
        // Defaults form a no-op
        dec.aluOp = mipsPkg::aluAdd;
        dec.useImm = 1'b0;
        dec.immZeroExtend = 1'b0;
        dec.writesReg = 1'b0;
        dec.destReg = dec.rd;
        dec.linkWrite = 1'b0;
        dec.isLoad = 1'b0;
        dec.isStore = 1'b0;
        dec.branchKind = mipsPkg::brNone;
        case (opcode)
            mipsPkg::opR: begin
                dec.writesReg = 1'b1;
                case (funct)
                    mipsPkg::fnAddu: dec.aluOp = mipsPkg::aluAdd;
                    mipsPkg::fnSubu: dec.aluOp = mipsPkg::aluSub;
                    mipsPkg::fnAnd: dec.aluOp = mipsPkg::aluAnd;
                    mipsPkg::fnOr: dec.aluOp = mipsPkg::aluOr;
                    mipsPkg::fnXor: dec.aluOp = mipsPkg::aluXor;
                    mipsPkg::fnSlt: dec.aluOp = mipsPkg::aluSlt;
                    mipsPkg::fnSltu: dec.aluOp = mipsPkg::aluSltu;
                    mipsPkg::fnSll: dec.aluOp = mipsPkg::aluSll;
                    mipsPkg::fnSrl: dec.aluOp = mipsPkg::aluSrl;
                    mipsPkg::fnSra: dec.aluOp = mipsPkg::aluSra;
                    mipsPkg::fnJr: begin
                        dec.writesReg = 1'b0;
                        dec.branchKind = mipsPkg::brJr;
                    end
                    default: dec.writesReg = 1'b0;
                endcase
            end
            mipsPkg::opJ: dec.branchKind = mipsPkg::brJump;
            mipsPkg::opJal: begin
                // Return address goes to ra
                dec.branchKind = mipsPkg::brJump;
                dec.writesReg = 1'b1;
                dec.linkWrite = 1'b1;
                dec.destReg = mipsPkg::regRa;
            end
            mipsPkg::opBeq: dec.branchKind = mipsPkg::brBeq;
            mipsPkg::opBne: dec.branchKind = mipsPkg::brBne;
            mipsPkg::opAddiu, mipsPkg::opSlti, mipsPkg::opSltiu, mipsPkg::opAndi,
            mipsPkg::opOri, mipsPkg::opXori, mipsPkg::opLui: begin
                dec.useImm = 1'b1;
                dec.writesReg = 1'b1;
                dec.destReg = dec.rt;
                case (opcode)
                    mipsPkg::opSlti: dec.aluOp = mipsPkg::aluSlt;
                    // SLTIU still sign extends, compare is unsigned
                    mipsPkg::opSltiu: dec.aluOp = mipsPkg::aluSltu;
                    mipsPkg::opAndi: dec.aluOp = mipsPkg::aluAnd;
                    mipsPkg::opOri: dec.aluOp = mipsPkg::aluOr;
                    mipsPkg::opXori: dec.aluOp = mipsPkg::aluXor;
                    mipsPkg::opLui: dec.aluOp = mipsPkg::aluLui;
                    default: dec.aluOp = mipsPkg::aluAdd;
                endcase
                // Logical immediates are zero extended
                dec.immZeroExtend = (opcode == mipsPkg::opAndi) || (opcode == mipsPkg::opOri)
                    || (opcode == mipsPkg::opXori);
            end
            mipsPkg::opLw: begin
                // Written from readdata in MEM, not in EXEC
                dec.useImm = 1'b1;
                dec.isLoad = 1'b1;
                dec.writesReg = 1'b1;
                dec.destReg = dec.rt;
            end
            mipsPkg::opSw: begin
                dec.useImm = 1'b1;
                dec.isStore = 1'b1;
            end
            default: dec.writesReg = 1'b0;
        endcase
    end
endmodule

/* mipsCpuBus.sv */
// Top level of the multicycle MIPS core, an Avalon-MM master exposing v0 and an active flag
`timescale 1ns/1ps

module mipsCpuBus (
    input logic clk,
    input logic reset,
    output logic active,
    output mipsPkg::word_t registerV0,
    // Avalon master
    output mipsPkg::word_t address,
    output logic write,
    output logic read,
    input logic waitrequest,
    output mipsPkg::word_t writedata,
    output logic [3:0] byteenable,
    input mipsPkg::word_t readdata
);
    mipsPkg::word_t rsData;
    mipsPkg::word_t rtData;
    mipsPkg::word_t v0Data;
    mipsPkg::word_t aluResult;
    mipsPkg::word_t pc;
    mipsPkg::word_t pcPlus4;
    logic instrLoad;
    logic regWrite;
    logic pcAdvance;
    mipsPkg::wbSel_t writeSelect;

    // Decoded instruction bundle
    decodeIf decBus ();

    instrDecoder u_instrDecoder (
        .clk(clk),
        .reset(reset),
        .instrLoad(instrLoad),
        .readdata(readdata),
        .dec(decBus.producer)
    );

    // Load data comes straight from the bus, link value is PC+4
    registerFile u_registerFile (
        .clk(clk),
        .reset(reset),
        .dec(decBus.consumer),
        .regWrite(regWrite),
        .writeSelect(writeSelect),
        .aluResult(aluResult),
        .loadData(readdata),
        .linkValue(pcPlus4),
        .rsData(rsData),
        .rtData(rtData),
        .v0Data(v0Data)
    );

    alu u_alu (
        .dec(decBus.consumer),
        .rsData(rsData),
        .rtData(rtData),
        .result(aluResult)
    );

    pcUnit u_pcUnit (
        .clk(clk),
        .reset(reset),
        .dec(decBus.consumer),
        .pcAdvance(pcAdvance),
        .rsData(rsData),
        .rtData(rtData),
        .pc(pc),
        .pcPlus4(pcPlus4)
    );

    cpuControl u_cpuControl (
        .clk(clk),
        .reset(reset),
        .dec(decBus.consumer),
        .pc(pc),
        .aluResult(aluResult),
        .waitrequest(waitrequest),
        .address(address),
        .read(read),
        .write(write),
        .active(active),
        .byteenable(byteenable),
        .instrLoad(instrLoad),
        .regWrite(regWrite),
        .pcAdvance(pcAdvance),
        .writeSelect(writeSelect)
    );

    // Store data is rt, valid through MEM
    assign writedata = rtData;
    assign registerV0 = v0Data;
endmodule

/* mipsPkg.sv */
// Widths, encodings and constants shared by every unit of the multicycle MIPS core
package mipsPkg;

    // Data path widths
    typedef logic [31:0] word_t;
    typedef logic [4:0] regAddr_t;
    typedef logic [4:0] shamt_t;
    typedef logic [15:0] imm_t;

    // Register file write source
    typedef logic [1:0] wbSel_t;
    localparam wbSel_t wbAlu = 2'd0;
    localparam wbSel_t wbLoad = 2'd1;
    localparam wbSel_t wbLink = 2'd2;

    // Primary opcodes, standard MIPS encoding
    typedef enum logic [5:0] {
        opR = 6'd0,
        opJ = 6'd2,
        opJal = 6'd3,
        opBeq = 6'd4,
        opBne = 6'd5,
        opAddiu = 6'd9,
        opSlti = 6'd10,
        opSltiu = 6'd11,
        opAndi = 6'd12,
        opOri = 6'd13,
        opXori = 6'd14,
        opLui = 6'd15,
        opLw = 6'd35,
        opSw = 6'd43
    } opcode_t;

    // R-type function codes
    typedef enum logic [5:0] {
        fnSll = 6'd0,
        fnSrl = 6'd2,
        fnSra = 6'd3,
        fnJr = 6'd8,
        fnAddu = 6'd33,
        fnSubu = 6'd35,
        fnAnd = 6'd36,
        fnOr = 6'd37,
        fnXor = 6'd38,
        fnSlt = 6'd42,
        fnSltu = 6'd43
    } funct_t;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt, aluSltu,
        aluSll, aluSrl, aluSra, aluLui
    } aluOp_t;

    // PC redirect classes
    typedef enum logic [2:0] {
        brNone, brBeq, brBne, brJump, brJr
    } branchKind_t;

    typedef enum logic [1:0] {
        stFetch, stExec, stMem, stHalt
    } cpuState_t;

    localparam word_t resetVector = 32'hBFC0_0000;
    // Fetching from here stops the core
    localparam word_t haltAddress = 32'h0000_0000;
    localparam regAddr_t regV0 = 5'd2;
    localparam regAddr_t regRa = 5'd31;
    localparam logic [3:0] fullByteEnable = 4'b1111;

endpackage

/* pcUnit.sv */
// Program counter with branch compare and next-address selection, updated once per instruction
`timescale 1ns/1ps

module pcUnit (
    input logic clk,
    input logic reset,
    decodeIf.consumer dec,
    input logic pcAdvance,
    input mipsPkg::word_t rsData,
    input mipsPkg::word_t rtData,
    output mipsPkg::word_t pc,
    output mipsPkg::word_t pcPlus4
);
    mipsPkg::word_t branchTarget;
    mipsPkg::word_t jumpTarget;
    mipsPkg::word_t nextPc;

    // Also the JAL link value
    assign pcPlus4 = pc + 32'd4;
    // Word offset relative to PC+4
    assign branchTarget = pcPlus4 + {{14{dec.imm[15]}}, dec.imm, 2'b00};
    // Region bits come from PC+4
    assign jumpTarget = {pcPlus4[31:28], dec.target, 2'b00};

    // No delay slot, redirect applies to the very next fetch
    always_comb begin
        case (dec.branchKind)
            mipsPkg::brBeq: nextPc = (rsData == rtData) ? branchTarget : pcPlus4;
            mipsPkg::brBne: nextPc = (rsData != rtData) ? branchTarget : pcPlus4;
            mipsPkg::brJump: nextPc = jumpTarget;
            mipsPkg::brJr: nextPc = rsData;
            default: nextPc = pcPlus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= mipsPkg::resetVector;
        end else if (pcAdvance) begin
            pc <= nextPc;
        end
    end
endmodule

/* registerFile.sv */
// General register file with two read ports, one write port and a fixed zero register
`timescale 1ns/1ps

module registerFile (
    input logic clk,
    input logic reset,
    decodeIf.consumer dec,
    input logic regWrite,
    input mipsPkg::wbSel_t writeSelect,
    input mipsPkg::word_t aluResult,
    input mipsPkg::word_t loadData,
    input mipsPkg::word_t linkValue,
    output mipsPkg::word_t rsData,
    output mipsPkg::word_t rtData,
    output mipsPkg::word_t v0Data
);
    mipsPkg::word_t regs [0:31];
    mipsPkg::word_t writeData;

    // Writeback source
    always_comb begin
        case (writeSelect)
            mipsPkg::wbLoad: writeData = loadData;
            mipsPkg::wbLink: writeData = linkValue;
            default: writeData = aluResult;
        endcase
    end

    // Register 0 is never written, so it stays at its reset value of zero
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite && (dec.destReg != '0)) begin
            regs[dec.destReg] <= writeData;
        end
    end

    // Asynchronous reads
    assign rsData = regs[dec.rs];
    assign rtData = regs[dec.rt];
    assign v0Data = regs[mipsPkg::regV0];
endmodule

/* run.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass line in the log
cd "$(dirname "$0")" &&
verilator --binary --timing -f compile.f --top-module tbMipsCpu &&
./obj_dir/VtbMipsCpu | tee sim.log &&
grep -qx "sim passed" sim.log ||
{ echo "simulation did not pass"; exit 1; }

/* tbMipsCpu.sv */
// Self-checking testbench for the MIPS core, runs a program table on an Avalon memory model
`timescale 1ns/1ps

module tbMipsCpu;
    // Run length limits
    localparam int numTests = 7;
    localparam int maxInstr = 8;
    localparam int resetCycles = 10;
    localparam int haltWindow = 20;
    // Three cycles per instruction, four times over for stalls, plus reset and halt watch
    localparam int watchdogCycles = numTests * (maxInstr * 3 * 4 + resetCycles + haltWindow);

    // Memory map
    localparam mipsPkg::word_t progBase = 32'hBFC0_0000;
    localparam mipsPkg::word_t dataBase = 32'h0000_1000;

    // Standard MIPS opcodes
    localparam logic [5:0] opJ = 6'd2;
    localparam logic [5:0] opJal = 6'd3;
    localparam logic [5:0] opBeq = 6'd4;
    localparam logic [5:0] opBne = 6'd5;
    localparam logic [5:0] opAddiu = 6'd9;
    localparam logic [5:0] opSlti = 6'd10;
    localparam logic [5:0] opXori = 6'd14;
    localparam logic [5:0] opOri = 6'd13;
    localparam logic [5:0] opLui = 6'd15;
    localparam logic [5:0] opLw = 6'd35;
    localparam logic [5:0] opSw = 6'd43;
    // R-type function codes
    localparam logic [5:0] fnSll = 6'd0;
    localparam logic [5:0] fnSrl = 6'd2;
    localparam logic [5:0] fnSra = 6'd3;
    localparam logic [5:0] fnJr = 6'd8;
    localparam logic [5:0] fnAddu = 6'd33;
    localparam logic [5:0] fnSubu = 6'd35;
    localparam logic [5:0] fnAnd = 6'd36;
    localparam logic [5:0] fnOr = 6'd37;
    localparam logic [5:0] fnXor = 6'd38;
    localparam logic [5:0] fnSlt = 6'd42;
    localparam logic [5:0] fnSltu = 6'd43;
    // Register numbers
    localparam mipsPkg::regAddr_t rZero = 5'd0;
    localparam mipsPkg::regAddr_t rV0 = 5'd2;
    localparam mipsPkg::regAddr_t rT0 = 5'd8;
    localparam mipsPkg::regAddr_t rT1 = 5'd9;
    localparam mipsPkg::regAddr_t rT2 = 5'd10;
    localparam mipsPkg::regAddr_t rT3 = 5'd11;
    localparam mipsPkg::regAddr_t rT4 = 5'd12;
    localparam mipsPkg::regAddr_t rT5 = 5'd13;
    localparam mipsPkg::regAddr_t rRa = 5'd31;

    logic clk = 1'b0;
    logic reset = 1'b1;
    logic waitrequest = 1'b0;
    mipsPkg::word_t readdata = '0;
    logic active;
    mipsPkg::word_t registerV0;
    mipsPkg::word_t address;
    logic read;
    logic write;
    mipsPkg::word_t writedata;
    logic [3:0] byteenable;

    // Test table, first listed word sits at the top of each packed entry
    string testName [0:7];
    logic [7:0][31:0] progTable [0:7];
    logic [3:0][31:0] dataTable [0:7];
    mipsPkg::word_t expV0 [0:7];
    logic expStore [0:7];
    mipsPkg::word_t expStoreAddr [0:7];
    mipsPkg::word_t expStoreData [0:7];

    // Memory model and observed stores
    mipsPkg::word_t progMem [0:7];
    mipsPkg::word_t dataMem [0:15];
    mipsPkg::word_t storeAddrs [$];
    mipsPkg::word_t storeDatas [$];
    logic [3:0] storeEnables [$];
    mipsPkg::word_t lfsrState = 32'h9647;

    mipsCpuBus u_dut (
        .clk(clk),
        .reset(reset),
        .active(active),
        .registerV0(registerV0),
        .address(address),
        .write(write),
        .read(read),
        .waitrequest(waitrequest),
        .writedata(writedata),
        .byteenable(byteenable),
        .readdata(readdata)
    );

    always #5 clk = ~clk;

    // Instruction assembly
    function automatic mipsPkg::word_t rType(input logic [5:0] fn, input mipsPkg::regAddr_t rd,
        input mipsPkg::regAddr_t rs, input mipsPkg::regAddr_t rt, input mipsPkg::shamt_t sh);
        return {6'd0, rs, rt, rd, sh, fn};
    endfunction

    function automatic mipsPkg::word_t iType(input logic [5:0] op, input mipsPkg::regAddr_t rt,
        input mipsPkg::regAddr_t rs, input mipsPkg::imm_t imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic mipsPkg::word_t jType(input logic [5:0] op, input mipsPkg::word_t addr);
        return {op, addr[27:2]};
    endfunction

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic mipsPkg::word_t lfsrNext(input mipsPkg::word_t s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Untouched data words, every address bit shows up
    function automatic mipsPkg::word_t fillWord(input mipsPkg::word_t addr);
        return addr ^ 32'h5A5A_C3C3;
    endfunction

    function automatic logic programHit(input mipsPkg::word_t addr);
        return (addr >= progBase) && (addr < progBase + 32'd32) && (addr[1:0] == 2'b00);
    endfunction

    function automatic logic dataHit(input mipsPkg::word_t addr);
        return (addr >= dataBase) && (addr < dataBase + 32'd64) && (addr[1:0] == 2'b00);
    endfunction

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic checkWord(input string name, input mipsPkg::word_t expected,
        input mipsPkg::word_t actual);
        if (actual !== expected) begin
            abortRun($sformatf("MISMATCH %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            abortRun($sformatf("MISMATCH %s expected %b actual %b", name, expected, actual));
        end
    endtask

    task automatic defineTest(input logic [2:0] idx, input string name,
        input logic [7:0][31:0] prog, input logic [3:0][31:0] data, input mipsPkg::word_t v0,
        input logic hasStore, input mipsPkg::word_t storeAddr, input mipsPkg::word_t storeData);
        testName[idx] = name;
        progTable[idx] = prog;
        dataTable[idx] = data;
        expV0[idx] = v0;
        expStore[idx] = hasStore;
        expStoreAddr[idx] = storeAddr;
        expStoreData[idx] = storeData;
    endtask

    // Completing cycle of a bus access
    task automatic serviceAccess();
        if (write) begin
            if (!dataHit(address)) begin
                abortRun($sformatf("store to an unmapped or misaligned address %h", address));
            end else begin
                storeAddrs.push_back(address);
                storeDatas.push_back(writedata);
                storeEnables.push_back(byteenable);
                dataMem[address[5:2]] = writedata;
            end
        end else if (programHit(address)) begin
            readdata = progMem[address[4:2]];
        end else if (dataHit(address)) begin
            readdata = dataMem[address[5:2]];
        end else begin
            abortRun($sformatf("read from an unmapped or misaligned address %h", address));
        end
    endtask

    // One clock, bus inputs change on the falling edge
    task automatic stepCycle();
        @(negedge clk);
        if (read && write) begin
            abortRun("read and write were asserted in the same cycle");
        end
        if (read || write) begin
            // One LFSR bit per access cycle, a 1 stalls it
            lfsrState = lfsrNext(lfsrState);
            waitrequest = lfsrState[0];
        end else begin
            waitrequest = 1'b0;
        end
        if ((read || write) && !waitrequest) begin
            serviceAccess();
        end
    endtask

    task automatic loadEntry(input logic [2:0] idx);
        for (int i = 0; i < 8; i++) begin
            progMem[i[2:0]] = progTable[idx][3'd7 - i[2:0]];
        end
        for (int i = 0; i < 16; i++) begin
            if (i < 4) begin
                dataMem[i[3:0]] = dataTable[idx][2'd3 - i[1:0]];
            end else begin
                dataMem[i[3:0]] = fillWord(dataBase + mipsPkg::word_t'(i * 4));
            end
        end
        storeAddrs.delete();
        storeDatas.delete();
        storeEnables.delete();
    endtask

    task automatic verifyStores(input logic [2:0] idx, input string name);
        if (expStore[idx]) begin
            checkWord({name, " store count"}, 32'd1, mipsPkg::word_t'(storeAddrs.size()));
            checkWord({name, " store address"}, expStoreAddr[idx], storeAddrs[0]);
            checkWord({name, " store data"}, expStoreData[idx], storeDatas[0]);
            checkWord({name, " byteenable"}, 32'h0000_000F, {28'd0, storeEnables[0]});
        end else begin
            checkWord({name, " store count"}, 32'd0, mipsPkg::word_t'(storeAddrs.size()));
        end
    endtask

    task automatic runTest(input logic [2:0] idx);
        string name;
        name = testName[idx];
        reset = 1'b1;
        loadEntry(idx);
        repeat (resetCycles) begin
            stepCycle();
            checkFlag({name, " read in reset"}, 1'b0, read);
            checkFlag({name, " write in reset"}, 1'b0, write);
        end
        checkFlag({name, " active after reset"}, 1'b1, active);
        reset = 1'b0;
        // Watchdog catches a core that never halts
        while (active) begin
            stepCycle();
        end
        // Bus stays idle once halted
        repeat (haltWindow) begin
            stepCycle();
            checkFlag({name, " read while halted"}, 1'b0, read);
            checkFlag({name, " write while halted"}, 1'b0, write);
            checkFlag({name, " active while halted"}, 1'b0, active);
        end
        checkWord({name, " v0"}, expV0[idx], registerV0);
        verifyStores(idx, name);
    endtask

    initial begin
        // 0x30 - 0xFFFF0010 = 0x10020, negative sum is less, so v0 gets 0x10021
        defineTest(3'd0, "aluArith", {
            iType(opLui, rT0, rZero, 16'hFFFF), iType(opOri, rT0, rT0, 16'h0010),
            iType(opAddiu, rT1, rZero, 16'h0030), rType(fnAddu, rT2, rT0, rT1, 5'd0),
            rType(fnSubu, rT3, rT1, rT0, 5'd0), rType(fnSlt, rT4, rT2, rT3, 5'd0),
            rType(fnAddu, rV0, rT3, rT4, 5'd0), rType(fnJr, rZero, rZero, rZero, 5'd0)
        }, '0, 32'h0001_0021, 1'b0, '0, '0);
        // 0x0FF0 from the logic chain plus one from SLTU
        defineTest(3'd1, "aluLogic", {
            iType(opAddiu, rT0, rZero, 16'h00FF), iType(opXori, rT1, rT0, 16'h0FF0),
            rType(fnAnd, rT2, rT0, rT1, 5'd0), rType(fnOr, rT3, rT0, rT1, 5'd0),
            rType(fnXor, rT4, rT3, rT2, 5'd0), rType(fnSltu, rT5, rT2, rT4, 5'd0),
            rType(fnAddu, rV0, rT4, rT5, 5'd0), rType(fnJr, rZero, rZero, rZero, 5'd0)
        }, '0, 32'h0000_0FF1, 1'b0, '0, '0);
        // 0xF8421000 ^ 0x08421000, then SLTI sees a negative value
        defineTest(3'd2, "aluShift", {
            iType(opLui, rT0, rZero, 16'h8421), rType(fnSra, rT1, rZero, rT0, 5'd4),
            rType(fnSrl, rT2, rZero, rT0, 5'd8), rType(fnSll, rT3, rZero, rT2, 5'd4),
            rType(fnXor, rT4, rT1, rT3, 5'd0), iType(opSlti, rT5, rT4, 16'h0001),
            rType(fnAddu, rV0, rT4, rT5, 5'd0), rType(fnJr, rZero, rZero, rZero, 5'd0)
        }, '0, 32'hF000_0001, 1'b0, '0, '0);
        defineTest(3'd3, "zeroReg", {
            iType(opAddiu, rV0, rZero, 16'h0005), iType(opAddiu, rZero, rZero, 16'h1234),
            rType(fnAddu, rV0, rZero, rZero, 5'd0), rType(fnJr, rZero, rZero, rZero, 5'd0),
            32'h0, 32'h0, 32'h0, 32'h0
        }, '0, 32'h0000_0000, 1'b0, '0, '0);
        // 0x1111 + 0x22220000 + 0x0101 stored at 0x1010 and read back
        defineTest(3'd4, "loadStore", {
            iType(opAddiu, rT0, rZero, 16'h1000), iType(opLw, rT1, rT0, 16'h0000),
            iType(opLw, rT2, rT0, 16'h0004), rType(fnAddu, rT3, rT1, rT2, 5'd0),
            iType(opAddiu, rT3, rT3, 16'h0101), iType(opSw, rT3, rT0, 16'h0010),
            iType(opLw, rV0, rT0, 16'h0010), rType(fnJr, rZero, rZero, rZero, 5'd0)
        }, {32'h0000_1111, 32'h2222_0000, 32'h0, 32'h0}, 32'h2222_1212,
            1'b1, 32'h0000_1010, 32'h2222_1212);
        // BEQ skips the 0xBAD write, BNE falls through into both adds
        defineTest(3'd5, "branches", {
            iType(opAddiu, rT0, rZero, 16'h0007), iType(opAddiu, rT1, rZero, 16'h0007),
            iType(opBeq, rT1, rT0, 16'h0001), iType(opAddiu, rV0, rZero, 16'h0BAD),
            iType(opBne, rT1, rT0, 16'h0001), iType(opAddiu, rV0, rV0, 16'h0010),
            iType(opAddiu, rV0, rV0, 16'h0001), rType(fnJr, rZero, rZero, rZero, 5'd0)
        }, '0, 32'h0000_0011, 1'b0, '0, '0);
        // JAL sits at word 1, so ra is its address plus four
        defineTest(3'd6, "jumpLink", {
            iType(opAddiu, rV0, rZero, 16'h0001), jType(opJal, progBase + 32'd12),
            iType(opAddiu, rV0, rZero, 16'h0BAD), jType(opJ, progBase + 32'd20),
            iType(opAddiu, rV0, rZero, 16'h0BAD), rType(fnAddu, rV0, rRa, rZero, 5'd0),
            rType(fnJr, rZero, rZero, rZero, 5'd0), 32'h0
        }, '0, progBase + 32'd8, 1'b0, '0, '0);
        for (int t = 0; t < numTests; t++) begin
            runTest(t[2:0]);
        end
        $display("sim passed");
        $finish;
    end

    // Watchdog
    initial begin
        repeat (watchdogCycles) @(posedge clk);
        abortRun("the processor never halted before the watchdog expired");
    end
endmodule
